// ==== source/board_pkg.sv ====
package board_pkg;

	localparam int BUTTON_COUNT = 6;

	// Bit order up, down, left, right, a, b
	typedef logic [BUTTON_COUNT-1:0] button_vec_t;

	localparam int BTN_UP    = 0;
	localparam int BTN_DOWN  = 1;
	localparam int BTN_LEFT  = 2;
	localparam int BTN_RIGHT = 3;
	localparam int BTN_A     = 4;
	localparam int BTN_B     = 5;

	localparam int DEFAULT_CLOCK_FREQ      = 25125000;
	localparam int DEFAULT_BAUD_RATE       = 115200;
	localparam int DEFAULT_SPI_DIV         = 2;
	localparam int DEFAULT_DEBOUNCE_CYCLES = 251250; // About 10 ms at the PLL clock

endpackage

// ==== source/proto_pkg.sv ====
package proto_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [23:0] flash_addr_t;

	// SPI flash READ is opcode then 24-bit address, then data
	localparam byte_t FLASH_CMD_READ = 8'h03;
	localparam int CMD_BITS  = $bits(byte_t) + $bits(flash_addr_t);
	localparam int DATA_BITS = $bits(byte_t);

	// Bytes per dump and page step
	localparam int PAGE_BYTES = 16;

	// 8N1 frame: start, 8 data, stop
	localparam int UART_FRAME_BITS = DATA_BITS + 2;

endpackage

// ==== source/flash_read_if.sv ====
`timescale 1ns/100ps

interface flash_read_if;
	import proto_pkg::*;

	logic        req;
	flash_addr_t addr;
	logic        ack;
	byte_t       data;

	modport controller (
		output req,
		output addr,
		input  ack,
		input  data
	);

	modport reader (
		input  req,
		input  addr,
		output ack,
		output data
	);

endinterface

// ==== source/button_debouncer.sv ====
`timescale 1ns/100ps

module button_debouncer #(
	parameter int DEBOUNCE_CYCLES = board_pkg::DEFAULT_DEBOUNCE_CYCLES
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  board_pkg::button_vec_t buttons,
	output board_pkg::button_vec_t press
);
	import board_pkg::*;

	localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

	button_vec_t   sync1;
	button_vec_t   sync2;
	button_vec_t   stable;
	logic [CW-1:0] cnt [BUTTON_COUNT];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sync1  <= '0;
			sync2  <= '0;
			stable <= '0;
			press  <= '0;
			for (int i = 0; i < BUTTON_COUNT; i++)
				cnt[i] <= '0;
		end
		else
		begin
			sync1 <= buttons;
			sync2 <= sync1;
			for (int i = 0; i < BUTTON_COUNT; i++)
			begin
				press[i] <= 1'b0;
				if (sync2[i] == stable[i])
					cnt[i] <= '0; // Bounce restarts the count
				else if (cnt[i] == CW'(DEBOUNCE_CYCLES - 1))
				begin
					stable[i] <= sync2[i];
					press[i]  <= sync2[i]; // Pulse on press only
					cnt[i]    <= '0;
				end
				else
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

endmodule

// ==== source/baud_timer.sv ====
`timescale 1ns/100ps

module baud_timer #(
	parameter int CLOCK_FREQ = board_pkg::DEFAULT_CLOCK_FREQ,
	parameter int BAUD_RATE  = board_pkg::DEFAULT_BAUD_RATE,
	parameter int SPI_DIV    = board_pkg::DEFAULT_SPI_DIV
) (
	input  logic clk,
	input  logic arst_n,
	output logic bit_tick,
	output logic spi_tick
);

	localparam int BAUD_DIV = CLOCK_FREQ / BAUD_RATE;
	localparam int BW = $clog2(BAUD_DIV + 1);
	localparam int SW = $clog2(SPI_DIV + 1);

	logic [BW-1:0] bit_cnt;
	logic [SW-1:0] spi_cnt;

	assign bit_tick = (bit_cnt == '0);
	assign spi_tick = (spi_cnt == '0);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt <= BW'(BAUD_DIV - 1);
			spi_cnt <= SW'(SPI_DIV - 1);
		end
		else
		begin
			bit_cnt <= bit_tick ? BW'(BAUD_DIV - 1) : bit_cnt - 1'b1; // Reload on terminal count
			spi_cnt <= spi_tick ? SW'(SPI_DIV - 1) : spi_cnt - 1'b1;
		end
	end

endmodule

// ==== source/dump_controller.sv ====
`timescale 1ns/100ps

module dump_controller (
	input  logic                   clk,
	input  logic                   arst_n,
	input  board_pkg::button_vec_t press,
	input  logic                   tx_ack,
	flash_read_if.controller       flash,
	output logic                   tx_req,
	output proto_pkg::byte_t       tx_data,
	output logic                   red_led,
	output logic                   green_led,
	output logic                   blue_led
);
	import board_pkg::*;
	import proto_pkg::*;

	localparam int IW = $clog2(PAGE_BYTES);
	localparam flash_addr_t PAGE_STEP = flash_addr_t'(PAGE_BYTES);

	typedef enum logic [2:0] {
		idle,
		read_req,
		read_wait_low,
		send_req,
		send_wait_low
	} state_t;

	state_t        state;
	flash_addr_t   page_addr;
	logic [IW-1:0] byte_idx;
	logic          abort_pending; // B seen during the dump
	logic          aborted;

	assign flash.req  = (state == read_req);
	assign flash.addr = page_addr + flash_addr_t'(byte_idx);
	assign tx_req     = (state == send_req);

	assign blue_led  = (state != idle);
	assign green_led = (state == idle) && !aborted;
	assign red_led   = aborted;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state         <= idle;
			page_addr     <= '0;
			byte_idx      <= '0;
			abort_pending <= 1'b0;
			aborted       <= 1'b0;
		end
		else
		begin
			if (state != idle && press[BTN_B])
				abort_pending <= 1'b1;
			case (state)
				idle:
					if (press[BTN_A])
					begin
						byte_idx      <= '0;
						abort_pending <= 1'b0;
						aborted       <= 1'b0;
						state         <= read_req;
					end
					else if (press[BTN_UP])
						page_addr <= page_addr + PAGE_STEP; // Wraps at 2^24
					else if (press[BTN_DOWN])
						page_addr <= page_addr - PAGE_STEP;
				read_req:
					if (flash.ack)
						state <= read_wait_low;
				read_wait_low:
					if (!flash.ack)
						state <= send_req;
				send_req:
					if (tx_ack)
						state <= send_wait_low;
				send_wait_low:
					if (!tx_ack)
					begin
						if (abort_pending || byte_idx == IW'(PAGE_BYTES - 1))
						begin
							aborted <= abort_pending;
							state   <= idle;
						end
						else
						begin
							byte_idx <= byte_idx + 1'b1;
							state    <= read_req;
						end
					end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == read_req && flash.ack)
			tx_data <= flash.data; // Byte held for the UART send
	end

endmodule

// ==== source/spi_flash_reader.sv ====
`timescale 1ns/100ps

module spi_flash_reader (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         spi_tick,
	flash_read_if.reader flash,
	input  logic         spi_miso,
	output logic         spi_mosi,
	output logic         spi_sck,
	output logic         spi_cs_n
);
	import proto_pkg::*;

	localparam int XFER_BITS = CMD_BITS + DATA_BITS;
	localparam int CW = $clog2(XFER_BITS);

	typedef enum logic [2:0] {
		idle,
		cs_setup,
		xfer,
		cs_hold,
		finish,
		ack_high
	} state_t;

	state_t              state;
	logic [CMD_BITS-1:0] tx_shift;
	byte_t               rx_shift;
	logic [CW-1:0]       bit_cnt;

	assign flash.data = rx_shift; // Static once the transfer is over

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= idle;
			spi_cs_n  <= 1'b1;
			spi_sck   <= 1'b0;
			spi_mosi  <= 1'b0;
			bit_cnt   <= '0;
			flash.ack <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (flash.req)
					begin
						spi_cs_n <= 1'b0;
						spi_mosi <= FLASH_CMD_READ[7]; // First bit valid before first rise
						bit_cnt  <= '0;
						state    <= cs_setup;
					end
				cs_setup:
					if (spi_tick)
						state <= xfer;
				xfer:
					if (spi_tick)
					begin
						spi_sck <= ~spi_sck;
						if (spi_sck)
						begin
							if (bit_cnt == CW'(XFER_BITS - 1))
								state <= cs_hold;
							else
							begin
								bit_cnt  <= bit_cnt + 1'b1;
								spi_mosi <= tx_shift[CMD_BITS-2]; // Change on falling edge
							end
						end
					end
				cs_hold:
					if (spi_tick)
					begin
						spi_cs_n <= 1'b1;
						spi_mosi <= 1'b0;
						state    <= finish;
					end
				finish:
				begin
					flash.ack <= 1'b1;
					state     <= ack_high;
				end
				ack_high:
					if (!flash.req)
					begin
						flash.ack <= 1'b0;
						state     <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && flash.req)
			tx_shift <= {FLASH_CMD_READ, flash.addr};
		else if (state == xfer && spi_tick && spi_sck)
			tx_shift <= tx_shift << 1; // Zeros follow the address
		if (state == xfer && spi_tick && !spi_sck)
			rx_shift <= {rx_shift[DATA_BITS-2:0], spi_miso}; // Sample on rising edge
	end

endmodule

// ==== source/uart_transmitter.sv ====
`timescale 1ns/100ps

module uart_transmitter (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             bit_tick,
	input  logic             tx_req,
	input  proto_pkg::byte_t tx_data,
	output logic             tx_ack,
	output logic             uart_tx
);
	import proto_pkg::*;

	localparam int CW = $clog2(UART_FRAME_BITS);

	typedef enum logic [1:0] {
		idle,
		arm,
		sending,
		done
	} state_t;

	state_t                     state;
	logic [UART_FRAME_BITS-1:0] frame;
	logic [CW-1:0]              bit_cnt;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= idle;
			uart_tx <= 1'b1;
			bit_cnt <= '0;
			tx_ack  <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (tx_req)
						state <= arm;
				arm:
					if (bit_tick)
					begin
						uart_tx <= frame[0]; // Start bit
						bit_cnt <= '0;
						state   <= sending;
					end
				sending:
					if (bit_tick)
					begin
						if (bit_cnt == CW'(UART_FRAME_BITS - 1))
						begin
							tx_ack <= 1'b1; // Stop bit done
							state  <= done;
						end
						else
						begin
							uart_tx <= frame[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				done:
					if (!tx_req)
					begin
						tx_ack <= 1'b0;
						state  <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && tx_req)
			frame <= {1'b1, tx_data, 1'b0}; // LSB first after start
		else if ((state == arm || state == sending) && bit_tick)
			frame <= {1'b1, frame[UART_FRAME_BITS-1:1]};
	end

endmodule

// ==== source/board_top.sv ====
`timescale 1ns/100ps

module board_top #(
	parameter int CLOCK_FREQ      = board_pkg::DEFAULT_CLOCK_FREQ,
	parameter int BAUD_RATE       = board_pkg::DEFAULT_BAUD_RATE,
	parameter int SPI_DIV         = board_pkg::DEFAULT_SPI_DIV,
	parameter int DEBOUNCE_CYCLES = board_pkg::DEFAULT_DEBOUNCE_CYCLES
) (
	input  logic clk,
	input  logic arst_n,
	input  logic up_button,
	input  logic down_button,
	input  logic a_button,
	input  logic b_button,
	input  logic spi_miso,
	output logic uart_tx,
	output logic spi_mosi,
	output logic spi_sck,
	output logic spi_cs_n,
	output logic red_led,
	output logic green_led,
	output logic blue_led
);
	import board_pkg::*;
	import proto_pkg::*;

	button_vec_t buttons;
	button_vec_t press;
	logic        bit_tick;
	logic        spi_tick;
	logic        tx_req;
	logic        tx_ack;
	byte_t       tx_data;

	flash_read_if i_flash_if ();

	assign buttons[BTN_UP]    = up_button;
	assign buttons[BTN_DOWN]  = down_button;
	assign buttons[BTN_LEFT]  = 1'b0; // Left and right not bonded out here
	assign buttons[BTN_RIGHT] = 1'b0;
	assign buttons[BTN_A]     = a_button;
	assign buttons[BTN_B]     = b_button;

	button_debouncer #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_debouncer (
		.clk     (clk),
		.arst_n  (arst_n),
		.buttons (buttons),
		.press   (press)
	);

	baud_timer #(
		.CLOCK_FREQ (CLOCK_FREQ),
		.BAUD_RATE  (BAUD_RATE),
		.SPI_DIV    (SPI_DIV)
	) i_timer (
		.clk      (clk),
		.arst_n   (arst_n),
		.bit_tick (bit_tick),
		.spi_tick (spi_tick)
	);

	dump_controller i_controller (
		.clk       (clk),
		.arst_n    (arst_n),
		.press     (press),
		.tx_ack    (tx_ack),
		.flash     (i_flash_if.controller),
		.tx_req    (tx_req),
		.tx_data   (tx_data),
		.red_led   (red_led),
		.green_led (green_led),
		.blue_led  (blue_led)
	);

	spi_flash_reader i_reader (
		.clk      (clk),
		.arst_n   (arst_n),
		.spi_tick (spi_tick),
		.flash    (i_flash_if.reader),
		.spi_miso (spi_miso),
		.spi_mosi (spi_mosi),
		.spi_sck  (spi_sck),
		.spi_cs_n (spi_cs_n)
	);

	uart_transmitter i_uart (
		.clk      (clk),
		.arst_n   (arst_n),
		.bit_tick (bit_tick),
		.tx_req   (tx_req),
		.tx_data  (tx_data),
		.tx_ack   (tx_ack),
		.uart_tx  (uart_tx)
	);

endmodule

// ==== verification/tb_models.sv ====
`timescale 1ns/100ps

module spi_flash_model (
	input  logic spi_cs_n,
	input  logic spi_sck,
	input  logic spi_mosi,
	output logic spi_miso,
	output logic bad_opcode
);
	import proto_pkg::*;

	logic [CMD_BITS-1:0] cmd_shift;
	byte_t               out_byte;
	int                  bit_count;

	initial
	begin
		spi_miso   = 1'b0;
		bad_opcode = 1'b0;
		cmd_shift  = '0;
		out_byte   = '0;
		bit_count  = 0;
	end

	always @(negedge spi_cs_n)
		bit_count = 0; // New transaction

	always @(posedge spi_sck)
	begin
		if (!spi_cs_n)
		begin
			cmd_shift = {cmd_shift[CMD_BITS-2:0], spi_mosi};
			bit_count = bit_count + 1;
			if (bit_count == CMD_BITS)
			begin
				if (cmd_shift[CMD_BITS-1 -: 8] != FLASH_CMD_READ)
					bad_opcode = 1'b1;
				out_byte = cmd_shift[7:0] ^ 8'h5A; // Content is low address byte xor 5A
			end
		end
	end

	// Data bits go out on falling edges after the command
	always @(negedge spi_sck)
	begin
		if (!spi_cs_n && bit_count >= CMD_BITS && bit_count < CMD_BITS + DATA_BITS)
		begin
			spi_miso <= out_byte[7];
			out_byte = {out_byte[6:0], 1'b0};
		end
	end

endmodule

module uart_monitor #(
	parameter int BIT_CYCLES = 8
) (
	input  logic clk,
	input  logic uart_tx,
	output logic bad_stop
);
	import proto_pkg::*;

	byte_t rx_queue [$];
	byte_t rx_byte;

	initial
	begin
		bad_stop = 1'b0;
		rx_byte  = '0;
		forever
		begin
			@(negedge uart_tx);
			repeat (BIT_CYCLES / 2) @(negedge clk); // Middle of the start bit
			if (uart_tx == 1'b0)
			begin
				for (int i = 0; i < DATA_BITS; i++)
				begin
					repeat (BIT_CYCLES) @(negedge clk);
					rx_byte[i] = uart_tx;
				end
				repeat (BIT_CYCLES) @(negedge clk);
				if (uart_tx !== 1'b1)
					bad_stop = 1'b1;
				else
					rx_queue.push_back(rx_byte);
			end
		end
	end

endmodule

// ==== verification/board_top_properties.sv ====
`timescale 1ns/100ps

module board_top_properties (
	input logic clk,
	input logic arst_n,
	input logic spi_cs_n,
	input logic spi_sck,
	input logic uart_tx,
	input logic flash_req,
	input logic flash_ack,
	input logic tx_req,
	input logic tx_ack
);

	logic uart_used; // A send was requested since reset

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			uart_used <= 1'b0;
		else if (tx_req)
			uart_used <= 1'b1;
	end

	// Both handshake lines low means the reader sits in idle
	cs_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(!flash_req && !flash_ack) |-> spi_cs_n)
		else $error("spi_cs_n low while the flash reader is idle");

	sck_parked: assert property (@(posedge clk) disable iff (!arst_n)
		spi_cs_n |-> !spi_sck)
		else $error("spi_sck high while spi_cs_n is high");

	flash_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		(flash_req && !flash_ack) |=> flash_req)
		else $error("flash req dropped before ack");

	tx_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		(tx_req && !tx_ack) |=> tx_req)
		else $error("tx_req dropped before tx_ack");

	flash_ack_order: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(flash_ack) |-> !flash_req)
		else $error("flash ack fell while req was high");

	tx_ack_order: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(tx_ack) |-> !tx_req)
		else $error("tx_ack fell while tx_req was high");

	uart_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		!uart_used |-> uart_tx)
		else $error("uart_tx left idle before the first send");

endmodule

bind board_top board_top_properties i_properties (
	.clk       (clk),
	.arst_n    (arst_n),
	.spi_cs_n  (spi_cs_n),
	.spi_sck   (spi_sck),
	.uart_tx   (uart_tx),
	.flash_req (i_flash_if.req),
	.flash_ack (i_flash_if.ack),
	.tx_req    (tx_req),
	.tx_ack    (tx_ack)
);

// ==== verification/tb_board_top.sv ====
`timescale 1ns/100ps

module tb_board_top;
	import board_pkg::*;
	import proto_pkg::*;

	localparam int CLOCK_FREQ      = 1000000;
	localparam int BAUD_RATE       = 125000;
	localparam int SPI_DIV         = 2;
	localparam int DEBOUNCE_CYCLES = 4;
	localparam int CLK_PERIOD      = 8;
	localparam int BIT_CYCLES      = CLOCK_FREQ / BAUD_RATE;
	localparam int HOLD_CYCLES     = DEBOUNCE_CYCLES + 6;
	localparam int DUMP_COUNT      = 6; // Dumps started by the test sequence
	localparam int DUMP_NS = PAGE_BYTES * (42 * 2 * SPI_DIV + 10 * BIT_CYCLES) * CLK_PERIOD;
	localparam int WATCHDOG_NS     = 3 * DUMP_COUNT * DUMP_NS;
	localparam logic [31:0] SEED   = 32'h1b00f99d;

	logic        clk;
	logic        arst_n;
	button_vec_t buttons;
	logic        spi_miso;
	logic        uart_tx;
	logic        spi_mosi;
	logic        spi_sck;
	logic        spi_cs_n;
	logic        red_led;
	logic        green_led;
	logic        blue_led;
	logic [2:0]  leds;
	logic        bad_opcode;
	logic        bad_stop;
	flash_addr_t page_addr; // Expected page address
	int          error_count;
	int          seed_state;

	assign leds = {red_led, green_led, blue_led};

	board_top #(
		.CLOCK_FREQ      (CLOCK_FREQ),
		.BAUD_RATE       (BAUD_RATE),
		.SPI_DIV         (SPI_DIV),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.up_button   (buttons[BTN_UP]),
		.down_button (buttons[BTN_DOWN]),
		.a_button    (buttons[BTN_A]),
		.b_button    (buttons[BTN_B]),
		.spi_miso    (spi_miso),
		.uart_tx     (uart_tx),
		.spi_mosi    (spi_mosi),
		.spi_sck     (spi_sck),
		.spi_cs_n    (spi_cs_n),
		.red_led     (red_led),
		.green_led   (green_led),
		.blue_led    (blue_led)
	);

	spi_flash_model i_flash (
		.spi_cs_n   (spi_cs_n),
		.spi_sck    (spi_sck),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso),
		.bad_opcode (bad_opcode)
	);

	uart_monitor #(
		.BIT_CYCLES (BIT_CYCLES)
	) i_uart_mon (
		.clk      (clk),
		.uart_tx  (uart_tx),
		.bad_stop (bad_stop)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compare_byte(input string name, input byte_t actual, input byte_t expected);
		if (actual !== expected)
			fail_run($sformatf("Mismatch %s: got 0x%02h, expected 0x%02h", name, actual, expected));
	endtask

	task automatic compare_leds(input logic [2:0] actual, input logic [2:0] expected);
		if (actual !== expected)
			fail_run($sformatf("Mismatch leds {r,g,b}: got 0x%0h, expected 0x%0h",
				actual, expected));
	endtask

	task automatic compare_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	task automatic compare_count(input string name, input int actual, input int expected);
		if (actual != expected)
			fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	function automatic byte_t flash_pattern(input flash_addr_t addr);
		return addr[7:0] ^ 8'h5A;
	endfunction

	task automatic press_button(input int index);
		@(negedge clk);
		buttons[index] = 1'b1;
		repeat (HOLD_CYCLES) @(negedge clk);
		buttons[index] = 1'b0;
		repeat (HOLD_CYCLES) @(negedge clk);
	endtask

	task automatic wait_dump_end();
		while (blue_led)
			@(negedge clk); // Watchdog bounds this
	endtask

	task automatic check_bytes(input flash_addr_t base, input int count);
		for (int i = 0; i < count; i++)
			compare_byte($sformatf("byte %0d", i), i_uart_mon.rx_queue[i],
				flash_pattern(base + flash_addr_t'(i)));
	endtask

	task automatic dump_full_page(input flash_addr_t base);
		i_uart_mon.rx_queue.delete();
		press_button(BTN_A);
		compare_leds(leds, 3'b001);
		wait_dump_end();
		compare_leds(leds, 3'b010);
		compare_count("byte count", i_uart_mon.rx_queue.size(), PAGE_BYTES);
		check_bytes(base, PAGE_BYTES);
	endtask

	task automatic test_reset_state();
		compare_leds(leds, 3'b010);
		compare_bit("uart_tx", uart_tx, 1'b1);
		compare_bit("spi_cs_n", spi_cs_n, 1'b1);
	endtask

	task automatic test_dump_page_zero();
		dump_full_page(page_addr);
	endtask

	task automatic test_page_moves();
		int n_up;
		int n_down;
		n_up   = 2 + int'($urandom % 4);
		n_down = 1 + int'($urandom % 32'(n_up - 1)); // At least one, fewer than ups
		for (int i = 0; i < n_up; i++)
		begin
			press_button(BTN_UP);
			page_addr = page_addr + flash_addr_t'(PAGE_BYTES);
		end
		for (int i = 0; i < n_down; i++)
		begin
			press_button(BTN_DOWN);
			page_addr = page_addr - flash_addr_t'(PAGE_BYTES);
		end
		dump_full_page(page_addr);
	endtask

	task automatic test_abort();
		int count;
		i_uart_mon.rx_queue.delete();
		press_button(BTN_A);
		while (i_uart_mon.rx_queue.size() < 2)
			@(negedge clk);
		press_button(BTN_B);
		wait_dump_end();
		count = i_uart_mon.rx_queue.size();
		if (count < 1 || count > PAGE_BYTES - 1)
			fail_run($sformatf("Aborted dump sent %0d bytes, outside 1 to %0d",
				count, PAGE_BYTES - 1));
		check_bytes(page_addr, count);
		compare_leds(leds, 3'b100);
		dump_full_page(page_addr); // Also checks that red is cleared
	endtask

	task automatic test_ignore_while_busy();
		i_uart_mon.rx_queue.delete();
		press_button(BTN_A);
		press_button(BTN_UP);
		press_button(BTN_UP);
		press_button(BTN_DOWN); // Net move of one page if taken
		press_button(BTN_A);
		compare_leds(leds, 3'b001);
		wait_dump_end();
		compare_leds(leds, 3'b010);
		compare_count("byte count", i_uart_mon.rx_queue.size(), PAGE_BYTES);
		check_bytes(page_addr, PAGE_BYTES);
		dump_full_page(page_addr); // Page address must be unchanged
	endtask

	always @(posedge bad_opcode)
		fail_run("Flash model received an opcode other than READ");

	always @(posedge bad_stop)
		fail_run("UART monitor saw a frame with a bad stop bit");

	initial
	begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired before the tests finished");
	end

	initial
	begin
		buttons     = '0;
		arst_n      = 1'b0;
		page_addr   = '0;
		error_count = 0;
		seed_state  = $urandom(SEED);
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		test_reset_state();
		test_dump_page_zero();
		test_page_moves();
		test_abort();
		test_ignore_while_busy();
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== compile.f ====
source/board_pkg.sv
source/proto_pkg.sv
source/flash_read_if.sv
source/button_debouncer.sv
source/baud_timer.sv
source/dump_controller.sv
source/spi_flash_reader.sv
source/uart_transmitter.sv
source/board_top.sv
verification/tb_models.sv
verification/board_top_properties.sv
verification/tb_board_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
